// ==== Makefile ====
# Verilator build, run and lint for the bus slicer testbench.

TOP := tb_bus_slicer

.PHONY: all run lint clean

all: run

# The run fails unless the testbench prints its pass line.
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

obj_dir/V$(TOP): pipe_slicer.f rtl/*.sv rtl/*.svh dv/*.sv dv/*.svh
	verilator --binary --timing -f pipe_slicer.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f pipe_slicer.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== dv/tb_slicer_checks.svh ====
// --------------------
// Stimulus table, scoreboard queues and typed compare tasks.
// Included inside the testbench module after both payload types
// are in scope. Stall values are thresholds out of 16.
// --------------------
`ifndef TB_SLICER_CHECKS_SVH
`define TB_SLICER_CHECKS_SVH

localparam int NUM_ENTRIES = 16;
localparam int STREAM_LEN  = 8;  // Leading entries replayed back to back at the end.

// Request payload of each entry.
localparam req_data_t REQ_TABLE [NUM_ENTRIES] = '{
  40'h00_0000_0000, 40'hff_ffff_ffff, 40'haa_aaaa_aaaa, 40'h55_5555_5555,
  40'h01_2345_6789, 40'hfe_dcba_9876, 40'h80_0000_0001, 40'h7f_ffff_fffe,
  40'h12_c0de_0042, 40'h3c_5a5a_a5a5, 40'hde_adbe_ef01, 40'h00_0001_0000,
  40'h9a_bcde_f012, 40'h44_3322_1100, 40'hc3_0f0f_f0f0, 40'h66_6666_6666
};

// Response payload of each entry, status bits on top.
localparam rsp_data_t RSP_TABLE [NUM_ENTRIES] = '{
  34'h0_0000_0000, 34'h3_ffff_ffff, 34'h2_aaaa_aaaa, 34'h1_5555_5555,
  34'h0_1234_5678, 34'h3_8765_4321, 34'h2_0000_0001, 34'h1_ffff_fffe,
  34'h0_cafe_f00d, 34'h3_0bad_beef, 34'h1_0f0f_0f0f, 34'h2_f0f0_f0f0,
  34'h0_0000_8000, 34'h3_4000_0000, 34'h1_2468_ace0, 34'h2_1357_9bdf
};

// Sink stalls on a cycle when its random nibble is below this value.
localparam logic [3:0] STALL_TABLE [NUM_ENTRIES] = '{
  4'd0, 4'd8, 4'd4, 4'd8, 4'd2, 4'd6, 4'd0, 4'd8,
  4'd4, 4'd6, 4'd8, 4'd2, 4'd0, 4'd6, 4'd4, 4'd8
};

// --------------------
// Scoreboard.
// --------------------
req_data_t req_q [$];    // Accepted requests not yet delivered.
int        req_t_q [$];  // Input transfer cycle of each queued request.
rsp_data_t rsp_q [$];
int        rsp_t_q [$];

int req_errors   = 0;
int rsp_errors   = 0;
int count_errors = 0;
int proto_errors = 0;

task automatic check_req(input string name, input req_data_t exp, input req_data_t act);
  if (act !== exp) begin
    req_errors++;
    $display("Fail %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_rsp(input string name, input rsp_data_t exp, input rsp_data_t act);
  if (act !== exp) begin
    rsp_errors++;
    $display("Fail %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    count_errors++;
    $display("Fail %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

`endif

// ==== dv/tb_bus_slicer.sv ====
// --------------------
// Testbench for the bus slicer. Random sink stalls first, then a
// back-to-back stream with the sinks always ready.
// Latency and span checks apply to the stream phase only.
// --------------------
`timescale 1ns/1ns
`default_nettype none

`include "pipe_slicer_params.svh"

module tb_bus_slicer
  import slicer_payload_pkg::*;
  import slicer_cfg_pkg::*;
();

  logic      i_clk;
  logic      i_rst_n;
  logic      i_req_valid;
  logic      o_req_ready;
  req_data_t i_req_data;
  logic      o_req_valid;
  logic      i_req_ready;
  req_data_t o_req_data;
  logic      i_rsp_valid;
  logic      o_rsp_ready;
  rsp_data_t i_rsp_data;
  logic      o_rsp_valid;
  logic      i_rsp_ready;
  rsp_data_t o_rsp_data;

  `include "tb_slicer_checks.svh"

  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 4 + 50;

  int         seed = 32'h34e0bca7;
  logic [3:0] req_stall;
  logic [3:0] rsp_stall;
  logic       stream_on;         // Stream phase, sinks always ready.
  int         cycle = 0;
  int         last_rsp_in = -10;  // Cycle of the latest response input transfer.
  int         stream_req_count = 0;
  int         stream_req_first = 0;
  int         stream_req_last = 0;
  int         stream_rsp_count = 0;
  int         stream_rsp_first = 0;
  int         stream_rsp_last = 0;
  logic       req_hold = 1'b0;    // Request output stalled on the last edge.
  req_data_t  req_hold_data;
  logic       rsp_hold = 1'b0;
  rsp_data_t  rsp_hold_data;

  bus_slicer_top UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // --------------------
  // Sinks with random stalls.
  // --------------------
  initial begin
    logic [31:0] rnd;
    i_req_ready = 1'b1;
    i_rsp_ready = 1'b1;
    forever begin
      @(posedge i_clk);
      rnd = $random(seed);
      i_req_ready <= (rnd[3:0] >= req_stall);
      i_rsp_ready <= (rnd[7:4] >= rsp_stall);
    end
  end

  task automatic send_req(input req_data_t item);
    i_req_valid <= 1'b1;
    i_req_data  <= item;
    @(posedge i_clk);
    while (!o_req_ready) begin
      @(posedge i_clk);              // Valid and data stay put until accepted.
    end
  endtask

  task automatic send_rsp(input rsp_data_t item);
    i_rsp_valid <= 1'b1;
    i_rsp_data  <= item;
    @(posedge i_clk);
    while (!o_rsp_ready) begin
      @(posedge i_clk);
    end
  endtask

  task automatic watch_req();
    req_data_t exp;
    int        t_in;
    if (i_req_valid && o_req_ready) begin
      req_q.push_back(i_req_data);
      req_t_q.push_back(cycle);
      if (stream_on) begin
        if (stream_req_count == 0) begin
          stream_req_first = cycle;
        end
        stream_req_last = cycle;
        stream_req_count++;
      end
    end
    if (o_req_valid && i_req_ready) begin
      if (req_q.size() == 0) begin
        proto_errors++;
        $display("Request delivered with nothing pending at cycle %0d", cycle);
      end else begin
        exp  = req_q.pop_front();
        t_in = req_t_q.pop_front();
        check_req("req_order", exp, o_req_data);
        if (stream_on) begin
          check_count("req_latency", `REQ_STAGES, cycle - t_in);
        end
      end
    end
    if (req_hold && !o_req_valid) begin
      proto_errors++;
      $display("o_req_valid dropped while stalled at cycle %0d", cycle);
    end else if (req_hold) begin
      check_req("req_hold", req_hold_data, o_req_data);
    end
    req_hold      = o_req_valid && !i_req_ready;
    req_hold_data = o_req_data;
  endtask

  task automatic watch_rsp();
    rsp_data_t exp;
    int        t_in;
    if (i_rsp_valid && o_rsp_ready) begin
      if (last_rsp_in == cycle - 1) begin
        proto_errors++;
        $display("Response inputs accepted on adjacent cycles at cycle %0d", cycle);
      end
      last_rsp_in = cycle;
      rsp_q.push_back(i_rsp_data);
      rsp_t_q.push_back(cycle);
      if (stream_on) begin
        if (stream_rsp_count == 0) begin
          stream_rsp_first = cycle;
        end
        stream_rsp_last = cycle;
        stream_rsp_count++;
      end
    end
    if (o_rsp_valid && i_rsp_ready) begin
      if (rsp_q.size() == 0) begin
        proto_errors++;
        $display("Response delivered with nothing pending at cycle %0d", cycle);
      end else begin
        exp  = rsp_q.pop_front();
        t_in = rsp_t_q.pop_front();
        check_rsp("rsp_order", exp, o_rsp_data);
        if (stream_on) begin
          check_count("rsp_latency", `RSP_STAGES, cycle - t_in);
        end
      end
    end
    if (rsp_hold && !o_rsp_valid) begin
      proto_errors++;
      $display("o_rsp_valid dropped while stalled at cycle %0d", cycle);
    end else if (rsp_hold) begin
      check_rsp("rsp_hold", rsp_hold_data, o_rsp_data);
    end
    rsp_hold      = o_rsp_valid && !i_rsp_ready;
    rsp_hold_data = o_rsp_data;
  endtask

  // --------------------
  // Monitor and watchdog.
  // --------------------
  initial begin
    forever begin
      @(posedge i_clk);
      cycle++;
      if (i_rst_n) begin
        watch_req();
        watch_rsp();
      end
    end
  end

  task automatic print_counts();
    $display("Errors: request data %0d, response data %0d, counts %0d, protocol %0d",
             req_errors, rsp_errors, count_errors, proto_errors);
  endtask

  task automatic wait_drain();
    @(negedge i_clk);
    while (req_q.size() != 0 || rsp_q.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Run did not finish within %0d cycles, %0d requests and %0d responses pending",
             WATCHDOG_CYCLES, req_q.size(), rsp_q.size());
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------
  // Main sequence.
  // --------------------
  initial begin
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_data  = '0;
    i_rsp_valid = 1'b0;
    i_rsp_data  = '0;
    req_stall   = '0;
    rsp_stall   = '0;
    stream_on   = 1'b0;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    if (o_req_valid !== 1'b0 || o_rsp_valid !== 1'b0) begin
      proto_errors++;
      $display("An output valid is not low after reset");
    end
    if (o_req_ready !== 1'b1 || o_rsp_ready !== 1'b1) begin
      proto_errors++;
      $display("An input ready is not high after reset");
    end
    @(posedge i_clk);
    fork
      begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          req_stall <= STALL_TABLE[i];
          send_req(REQ_TABLE[i]);
        end
        i_req_valid <= 1'b0;
      end
      begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          rsp_stall <= STALL_TABLE[NUM_ENTRIES - 1 - i];  // Reversed for variety.
          send_rsp(RSP_TABLE[i]);
        end
        i_rsp_valid <= 1'b0;
      end
    join
    wait_drain();
    req_stall <= '0;
    rsp_stall <= '0;
    @(posedge i_clk);
    stream_on <= 1'b1;
    fork
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          send_req(REQ_TABLE[i]);
        end
        i_req_valid <= 1'b0;
      end
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          send_rsp(RSP_TABLE[i]);
        end
        i_rsp_valid <= 1'b0;
      end
    join
    wait_drain();
    check_count("req_stream_span", STREAM_LEN - 1, stream_req_last - stream_req_first);
    // A half-bandwidth chain takes a new item every second cycle.
    check_count("rsp_stream_span", 2 * (STREAM_LEN - 1), stream_rsp_last - stream_rsp_first);
    print_counts();
    if (req_errors + rsp_errors + count_errors + proto_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pipe_slicer.f ====
+incdir+rtl
+incdir+dv
rtl/slicer_payload_pkg.sv
rtl/slicer_cfg_pkg.sv
rtl/slicer_unit_half_bw.sv
rtl/slicer_unit_full_bw.sv
rtl/slicer_chain.sv
rtl/bus_slicer_top.sv
dv/tb_bus_slicer.sv

// ==== rtl/bus_slicer_top.sv ====
// --------------------
// Bus register slicer between one master and one slave.
// Request chain runs at full bandwidth, response chain at half.
// No address decoding, protocol conversion or clock crossing.
// --------------------
`timescale 1ns/1ns
`default_nettype none

`include "pipe_slicer_params.svh"

module bus_slicer_top
  import slicer_payload_pkg::*;
  import slicer_cfg_pkg::*;
(
  input  var logic      i_clk,
  input  var logic      i_rst_n,
  // Request from master.
  input  var logic      i_req_valid,
  output var logic      o_req_ready,
  input  var req_data_t i_req_data,
  // Request to slave.
  output var logic      o_req_valid,
  input  var logic      i_req_ready,
  output var req_data_t o_req_data,
  // Response from slave.
  input  var logic      i_rsp_valid,
  output var logic      o_rsp_ready,
  input  var rsp_data_t i_rsp_data,
  // Response to master.
  output var logic      o_rsp_valid,
  input  var logic      i_rsp_ready,
  output var rsp_data_t o_rsp_data
);

  // --------------------
  // Request path.
  // --------------------
  slicer_chain #(
    .WIDTH  (`REQ_WIDTH),
    .STAGES (`REQ_STAGES),
    .MODE   (SLICE_FULL_BW)
  ) u_req_chain (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_req_valid),
    .o_ready (o_req_ready),
    .i_data  (i_req_data),
    .o_valid (o_req_valid),
    .i_ready (i_req_ready),
    .o_data  (o_req_data)
  );

  // --------------------
  // Response path.
  // --------------------
  slicer_chain #(
    .WIDTH  (`RSP_WIDTH),
    .STAGES (`RSP_STAGES),
    .MODE   (SLICE_HALF_BW)
  ) u_rsp_chain (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_rsp_valid),
    .o_ready (o_rsp_ready),
    .i_data  (i_rsp_data),
    .o_valid (o_rsp_valid),
    .i_ready (i_rsp_ready),
    .o_data  (o_rsp_data)
  );

endmodule

`default_nettype wire

// ==== rtl/pipe_slicer_params.svh ====
// --------------------
// Channel widths and slice counts for the bus slicer.
// Each stage count must be at least one.
// Widths must match the payload fields the master and slave use.
// --------------------
`ifndef PIPE_SLICER_PARAMS_SVH
`define PIPE_SLICER_PARAMS_SVH

// Request payload is address, data and the write flag.
`define REQ_WIDTH 40

// Response payload is read data plus two status bits.
`define RSP_WIDTH 34

// --------------------
// Slice counts per channel.
// --------------------
`define REQ_STAGES 2

`define RSP_STAGES 3

`endif

// ==== rtl/slicer_cfg_pkg.sv ====
// --------------------
// Configuration types for the slice units and chains.
// --------------------
`default_nettype none

package slicer_cfg_pkg;

  // Kind of register slice used in a chain.
  typedef enum logic {
    SLICE_HALF_BW = 1'b0,  // One register, one item every two cycles.
    SLICE_FULL_BW = 1'b1   // Skid buffer, one item per cycle.
  } slice_mode_e;

  // --------------------
  // Skid-buffer occupancy.
  // --------------------
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,  // No item held.
    SKID_BUSY  = 2'd1,  // Main entry holds an item.
    SKID_FULL  = 2'd2   // Main and skid entries both hold an item.
  } skid_state_e;

endpackage

`default_nettype wire

// ==== rtl/slicer_chain.sv ====
// --------------------
// Chain of STAGES register slices of one kind.
// STAGES must be at least one. Latency with the sink always
// ready is STAGES cycles.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module slicer_chain
  import slicer_cfg_pkg::*;
#(
  parameter int          WIDTH  = 8,
  parameter int          STAGES = 1,
  parameter slice_mode_e MODE   = SLICE_FULL_BW
) (
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  // Upstream side.
  input  var logic             i_valid,
  output var logic             o_ready,
  input  var logic [WIDTH-1:0] i_data,
  // Downstream side.
  output var logic             o_valid,
  input  var logic             i_ready,
  output var logic [WIDTH-1:0] o_data
);

  // Link k sits in front of stage k; link STAGES is the chain output.
  logic [STAGES:0]  link_valid;
  logic [STAGES:0]  link_ready;
  logic [WIDTH-1:0] link_data [STAGES+1];

  assign link_valid[0]      = i_valid;
  assign link_data[0]       = i_data;
  assign o_ready            = link_ready[0];
  assign o_valid            = link_valid[STAGES];
  assign o_data             = link_data[STAGES];
  assign link_ready[STAGES] = i_ready;

  // --------------------
  // Stage instances.
  // --------------------
  for (genvar k = 0; k < STAGES; k++) begin : g_stage
    if (MODE == SLICE_FULL_BW) begin : g_full
      slicer_unit_full_bw #(
        .WIDTH (WIDTH)
      ) u_unit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (link_valid[k]),
        .o_ready (link_ready[k]),
        .i_data  (link_data[k]),
        .o_valid (link_valid[k+1]),
        .i_ready (link_ready[k+1]),
        .o_data  (link_data[k+1])
      );
    end else begin : g_half
      slicer_unit_half_bw #(
        .WIDTH (WIDTH)
      ) u_unit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (link_valid[k]),
        .o_ready (link_ready[k]),
        .i_data  (link_data[k]),
        .o_valid (link_valid[k+1]),
        .i_ready (link_ready[k+1]),
        .o_data  (link_data[k+1])
      );
    end
  end

endmodule

`default_nettype wire

// ==== rtl/slicer_payload_pkg.sv ====
// --------------------
// Payload types for both channels of the bus slicer.
// The slicer treats each payload as one opaque vector.
// --------------------
`default_nettype none

`include "pipe_slicer_params.svh"

package slicer_payload_pkg;

  // --------------------
  // Request channel, master to slave.
  // --------------------

  // Address, data and write flag packed by the master.
  typedef logic [`REQ_WIDTH-1:0] req_data_t;

  // --------------------
  // Response channel, slave to master.
  // --------------------

  // Read data with the two status bits on top.
  typedef logic [`RSP_WIDTH-1:0] rsp_data_t;

endpackage

`default_nettype wire

// ==== rtl/slicer_unit_full_bw.sv ====
// --------------------
// Two-entry skid-buffer slice. Sustains one item per cycle
// with a registered o_ready. o_ready drops only when both
// entries are full.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module slicer_unit_full_bw
  import slicer_cfg_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  // Upstream side.
  input  var logic             i_valid,
  output var logic             o_ready,
  input  var logic [WIDTH-1:0] i_data,
  // Downstream side.
  output var logic             o_valid,
  input  var logic             i_ready,
  output var logic [WIDTH-1:0] o_data
);

  skid_state_e      state;
  logic             ready_q;        // Registered upstream ready.
  logic [WIDTH-1:0] main_data;      // Entry presented at the output.
  logic [WIDTH-1:0] skid_data;      // Entry that absorbs a stalled item.
  logic             in_xfer;
  logic             out_xfer;
  logic             main_load_in;
  logic             main_load_skid;
  logic             skid_load;

  assign in_xfer  = i_valid && ready_q;
  assign out_xfer = o_valid && i_ready;

  // An incoming item goes to main when main is free or leaving now.
  assign main_load_in   = in_xfer && (!o_valid || out_xfer);
  assign skid_load      = in_xfer && o_valid && !out_xfer;  // Sink stalled.
  assign main_load_skid = (state == SKID_FULL) && out_xfer;  // Refill from skid.

  assign o_valid = (state != SKID_EMPTY);
  assign o_ready = ready_q;
  assign o_data  = main_data;

  // --------------------
  // Occupancy FSM.
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= SKID_EMPTY;
      ready_q <= 1'b1;
    end else begin
      case (state)
        SKID_EMPTY: begin
          if (in_xfer) begin
            state <= SKID_BUSY;
          end
        end
        SKID_BUSY: begin
          if (in_xfer && !out_xfer) begin
            state   <= SKID_FULL;
            ready_q <= 1'b0;          // Both entries now taken.
          end else if (!in_xfer && out_xfer) begin
            state <= SKID_EMPTY;
          end
        end
        SKID_FULL: begin
          if (out_xfer) begin
            state   <= SKID_BUSY;
            ready_q <= 1'b1;          // Skid entry moves into main.
          end
        end
        default: begin
          state   <= SKID_EMPTY;
          ready_q <= 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // Payload entries.
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_data <= '0;
    end else if (main_load_skid) begin
      main_data <= skid_data;         // Oldest item goes out next.
    end else if (main_load_in) begin
      main_data <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      skid_data <= '0;
    end else if (skid_load) begin
      skid_data <= i_data;            // Item accepted as ready fell.
    end
  end

endmodule

`default_nettype wire

// ==== rtl/slicer_unit_half_bw.sv ====
// --------------------
// Single-register slice. Ready only while empty, so it passes
// at most one item every two cycles.
// No combinational path runs from i_ready to o_ready.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module slicer_unit_half_bw #(
  parameter int WIDTH = 8
) (
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  // Upstream side.
  input  var logic             i_valid,
  output var logic             o_ready,
  input  var logic [WIDTH-1:0] i_data,
  // Downstream side.
  output var logic             o_valid,
  input  var logic             i_ready,
  output var logic [WIDTH-1:0] o_data
);

  logic             full;     // Register holds an item.
  logic [WIDTH-1:0] data_q;   // Held payload.
  logic             load;     // Input transfer this cycle.

  assign load    = !full && i_valid;  // Accept only into an empty register.
  assign o_ready = !full;
  assign o_valid = full;
  assign o_data  = data_q;

  // --------------------
  // Occupancy flag.
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full <= 1'b0;
    end else if (!full) begin
      full <= i_valid;                // Fill on any offered item.
    end else if (i_ready) begin
      full <= 1'b0;                   // Output transfer empties it.
    end
  end

  // --------------------
  // Payload register.
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_q <= '0;
    end else if (load) begin
      data_q <= i_data;               // Stays stable until the item leaves.
    end
  end

endmodule

`default_nettype wire
